//--- project.f
+incdir+.
spi_pkg.sv
sync_fifo.sv
spi_clk_gen.sv
spi_cmd_master.sv
wb_spi_regs.sv
spi_subsystem.sv
spi_periph_model.sv
tb_spi_subsystem.sv

//--- run.sh
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f project.f --top-module tb_spi_subsystem --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Done: no errors" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

//--- spi_clk_gen.sv
`default_nettype none

`include "spi_macros.svh"

module spi_clk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk_en,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  localparam int cnt_w = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`SPI_CLK_DIV - 1);

  logic [cnt_w-1:0] div_cnt;
  logic             toggle;

  assign toggle = sclk_en && (div_cnt == last_cnt);

  // Strobes are registered with sclk so they line up with its edges.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt   <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else if (!sclk_en)
    begin
      // Parked low so the next transfer opens on a full low half period.
      div_cnt   <= '0;
      sclk      <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end
    else
    begin
      div_cnt   <= toggle ? '0 : div_cnt + 1'b1;
      sclk_rise <= toggle && !sclk;
      sclk_fall <= toggle && sclk;
      if (toggle)
        sclk <= ~sclk;
    end
  end

endmodule

`default_nettype wire

//--- spi_cmd_master.sv
`default_nettype none

`include "spi_macros.svh"

module spi_cmd_master
  import spi_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  spi_cmd_t   cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       sclk,
  input  logic       sclk_rise,
  input  logic       sclk_fall,
  output logic       sclk_en,
  output logic       cs,
  output logic       mosi,
  input  logic       miso,
  output logic       read_vld,
  input  logic       read_rdy,
  output spi_rdata_t read_data
);

  localparam int total_bits = `SPI_CMD_WIDTH + `SPI_READ_WIDTH;
  localparam int bit_cnt_w  = $clog2(total_bits + 1);
  localparam logic [bit_cnt_w-1:0] last_cmd_bit  = bit_cnt_w'(`SPI_CMD_WIDTH - 1);
  localparam logic [bit_cnt_w-1:0] last_read_bit = bit_cnt_w'(total_bits - 1);

  spi_state_t           state;
  spi_cmd_t             shift_buf;
  spi_rdata_t           rx_buf;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic                 is_read;

  // Ready only while idle and a command is waiting.
  assign cmd_rdy   = (state == idle) && cmd_vld;
  assign read_data = rx_buf;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= idle;
      cs       <= 1'b1;
      sclk_en  <= 1'b0;
      mosi     <= 1'b0;
      read_vld <= 1'b0;
      bit_cnt  <= '0;
      is_read  <= 1'b0;
    end
    else
    begin
      case (state)
        idle:
        begin
          if (cmd_vld)
          begin
            state   <= shift_cmd;
            cs      <= 1'b0;
            sclk_en <= 1'b1;
            // MSB goes out ahead of the first rising edge.
            mosi    <= cmd_in[`SPI_CMD_WIDTH-1];
            is_read <= !cmd_in[`SPI_CMD_WIDTH-1];
            bit_cnt <= '0;
          end
        end
        shift_cmd:
        begin
          if (sclk_fall)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            mosi    <= shift_buf[`SPI_CMD_WIDTH-2];
            if (bit_cnt == last_cmd_bit)
            begin
              if (is_read)
              begin
                state <= shift_read;
              end
              else
              begin
                state   <= idle;
                cs      <= 1'b1;
                sclk_en <= 1'b0;
              end
            end
          end
        end
        shift_read:
        begin
          if (sclk_fall)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == last_read_bit)
            begin
              state   <= finish;
              cs      <= 1'b1;
              sclk_en <= 1'b0;
            end
          end
        end
        finish:
        begin
          // Hold the result until the read FIFO takes it.
          if (!read_vld)
          begin
            read_vld <= 1'b1;
          end
          else if (read_rdy)
          begin
            read_vld <= 1'b0;
            state    <= idle;
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
      shift_buf <= cmd_in;
    else if (state == shift_cmd && sclk_fall)
      shift_buf <= {shift_buf[`SPI_CMD_WIDTH-2:0], 1'b0};
    if (state == shift_read && sclk_rise)
      rx_buf <= {rx_buf[`SPI_READ_WIDTH-2:0], miso};
  end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk);

  a_no_write_result: assert property (@(posedge clk) disable iff (!rst_n)
    (state != idle && !is_read) |-> !read_vld);

endmodule

`default_nettype wire

//--- spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Command word.
// Bit 11 is the write flag, bits 10:8 the register address
// and bits 7:0 the write data.
`define SPI_CMD_WIDTH 12

// Bits clocked in after a read command.
`define SPI_READ_WIDTH 8

// clk cycles per sclk half period.
`define SPI_CLK_DIV 4

// Entries in the command and read FIFOs.
`define SPI_FIFO_DEPTH 4

// Host bus data width.
`define SPI_WB_WIDTH 16

`endif

//--- spi_periph_model.sv
`default_nettype none

module spi_periph_model (
  input  wire  sclk,
  input  wire  cs,
  input  wire  mosi,
  output logic miso,
  output int   errors
);

  timeunit 1ns;
  timeprecision 1ns;

  logic [7:0]  regs [8];
  logic [11:0] cmd_shift     = '0;
  logic [7:0]  tx_shift      = '0;
  logic        miso_q        = 1'b0;
  logic        cs_q          = 1'b1;
  logic        rd_cmd        = 1'b0;
  int          bit_cnt       = 0;
  int          count_errors  = 0;
  int          glitch_errors = 0;

  assign miso   = miso_q;
  assign errors = count_errors + glitch_errors;

  // Chip select edges frame a transfer; sclk rises shift the command in.
  always @(posedge cs or negedge cs or posedge sclk)
  begin
    if (cs !== cs_q)
    begin
      cs_q = cs;
      if (!cs)
      begin
        bit_cnt = 0;
        rd_cmd  = 1'b0;
      end
      else if (bit_cnt != 12 && bit_cnt != 20)
      begin
        count_errors++;
        $display("SPI peripheral counted %0d sclk bits in one chip select period", bit_cnt);
      end
    end
    else if (!cs)
    begin
      bit_cnt++;
      if (bit_cnt <= 12)
        cmd_shift = {cmd_shift[10:0], mosi};
      if (bit_cnt == 12)
      begin
        if (cmd_shift[11])
          regs[cmd_shift[10:8]] = cmd_shift[7:0];
        else
          rd_cmd = 1'b1;
      end
    end
  end

  // Read data leaves MSB first on the falls after the command.
  always @(negedge sclk)
  begin
    if (!cs && rd_cmd && bit_cnt >= 12 && bit_cnt < 20)
    begin
      if (bit_cnt == 12)
        tx_shift = regs[cmd_shift[10:8]];
      miso_q   = tx_shift[7];
      tx_shift = {tx_shift[6:0], 1'b0};
    end
  end

  always @(mosi)
  begin
    if (!cs && sclk)
    begin
      glitch_errors++;
      $display("SPI peripheral saw mosi change while sclk was high");
    end
  end

endmodule

`default_nettype wire

//--- spi_pkg.sv
`default_nettype none

`include "spi_macros.svh"

package spi_pkg;

  typedef logic [`SPI_CMD_WIDTH-1:0] spi_cmd_t;

  typedef logic [`SPI_READ_WIDTH-1:0] spi_rdata_t;

  // Master FSM.
  typedef enum logic [1:0] {
    idle,
    shift_cmd,
    shift_read,
    finish
  } spi_state_t;

  // Host register map.
  typedef enum logic [1:0] {
    reg_cmd    = 2'd0,
    reg_rdata  = 2'd1,
    reg_status = 2'd2
  } wb_reg_t;

endpackage

`default_nettype wire

//--- spi_subsystem.sv
`default_nettype none

`include "spi_macros.svh"

module spi_subsystem
  import spi_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [1:0]               wb_adr,
  input  logic [`SPI_WB_WIDTH-1:0] wb_dat_w,
  output logic [`SPI_WB_WIDTH-1:0] wb_dat_r,
  output logic                     wb_ack,
  output logic                     sclk,
  output logic                     cs,
  output logic                     mosi,
  input  logic                     miso
);

  logic       push_vld;
  logic       push_rdy;
  spi_cmd_t   push_cmd;
  logic       cmd_vld;
  logic       cmd_rdy;
  spi_cmd_t   cmd_in;
  logic       read_vld;
  logic       read_rdy;
  spi_rdata_t read_data;
  logic       rd_valid;
  logic       rd_ready;
  spi_rdata_t rd_data;
  logic       sclk_en;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       busy;

  // Busy covers the whole transfer and a result waiting on a full FIFO.
  assign busy = !cs || read_vld;

  wb_spi_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .cmd_valid (push_vld),
    .cmd_ready (push_rdy),
    .cmd_data  (push_cmd),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd_data   (rd_data),
    .busy      (busy)
  );

  sync_fifo #(.payload_t(spi_cmd_t)) u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (push_vld),
    .in_ready  (push_rdy),
    .in_data   (push_cmd),
    .out_valid (cmd_vld),
    .out_ready (cmd_rdy),
    .out_data  (cmd_in)
  );

  sync_fifo #(.payload_t(spi_rdata_t)) u_read_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (read_vld),
    .in_ready  (read_rdy),
    .in_data   (read_data),
    .out_valid (rd_valid),
    .out_ready (rd_ready),
    .out_data  (rd_data)
  );

  spi_cmd_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .sclk_en   (sclk_en),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  spi_clk_gen u_clk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk_en   (sclk_en),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

endmodule

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

`include "spi_macros.svh"

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = `SPI_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
  localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready  = (count != full_cnt);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n) count <= full_cnt);

endmodule

`default_nettype wire

//--- tb_spi_subsystem.sv
`default_nettype none

`include "spi_macros.svh"

module tb_spi_subsystem
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int ack_limit   = 5000;
  localparam int poll_limit  = 1000;
  localparam int stall_limit = 5000;
  localparam int num_random  = 200;

  logic                     clk;
  logic                     rst_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [1:0]               wb_adr;
  logic [`SPI_WB_WIDTH-1:0] wb_dat_w;
  logic [`SPI_WB_WIDTH-1:0] wb_dat_r;
  logic                     wb_ack;
  logic                     sclk;
  logic                     cs;
  logic                     mosi;
  logic                     miso;
  int                       periph_errors;
  int                       errors;
  int                       checks;
  logic [7:0]               ref_regs [8];

  spi_subsystem UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso)
  );

  spi_periph_model u_periph (
    .sclk   (sclk),
    .cs     (cs),
    .mosi   (mosi),
    .miso   (miso),
    .errors (periph_errors)
  );

  always #50 clk = ~clk;

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d, peripheral errors: %0d", checks, errors, periph_errors);
    if (errors == 0 && periph_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  // One classic cycle; the ack is seen one edge after the slave registers it.
  task automatic wb_access(input logic we, input wb_reg_t adr,
                           input logic [15:0] wdata, output logic [15:0] rdata);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    while (!acked && waited < ack_limit)
    begin
      @(posedge clk);
      waited++;
      acked = wb_ack;
    end
    rdata = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    if (!acked)
    begin
      errors++;
      $display("Wishbone ack never arrived for register %0d", adr);
      finish_run();
    end
  endtask

  task automatic issue_cmd(input logic wr, input logic [2:0] addr, input logic [7:0] data);
    logic [15:0] ack_word;
    wb_access(1'b1, reg_cmd, {4'h0, wr, addr, data}, ack_word);
    if (wr)
      ref_regs[addr] = data;
  endtask

  // Busy drops for a cycle between queued commands, so two low polls are needed.
  task automatic wait_idle();
    logic [15:0] status;
    int          polls;
    int          low_run;
    polls   = 0;
    low_run = 0;
    while (low_run < 2 && polls < poll_limit)
    begin
      wb_access(1'b0, reg_status, 16'h0000, status);
      polls++;
      low_run = status[2] ? 0 : low_run + 1;
    end
    if (low_run < 2)
    begin
      errors++;
      $display("Busy status never went low");
      finish_run();
    end
  endtask

  task automatic pop_result(output logic [15:0] word);
    int polls;
    polls = 0;
    word  = 16'h0000;
    while (!word[15] && polls < poll_limit)
    begin
      wb_access(1'b0, reg_rdata, 16'h0000, word);
      polls++;
    end
    if (!word[15])
    begin
      errors++;
      $display("No read result arrived in the read FIFO");
      finish_run();
    end
  endtask

  task automatic wait_master_stall();
    int waited;
    waited = 0;
    while (!(UUT.read_vld && !UUT.read_rdy) && waited < stall_limit)
    begin
      @(posedge clk);
      waited++;
    end
    if (!(UUT.read_vld && !UUT.read_rdy))
    begin
      errors++;
      $display("Master never stalled on a full read FIFO");
      finish_run();
    end
  endtask

  initial
  begin
    logic [15:0] word;
    logic [15:0] expected;
    logic [2:0]  addr;
    logic [7:0]  data;
    logic [2:0]  queued_addr [6];
    int          n;
    void'($urandom(32'hf7de));
    errors   = 0;
    checks   = 0;
    clk      = 1'b0;
    rst_n    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 2'd0;
    wb_dat_w = 16'h0000;
    #10;
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    wb_access(1'b0, reg_status, 16'h0000, word);
    checks++;
    if (word !== 16'h0002)
    begin
      errors++;
      $display("Fail reset status: expected %h, actual %h", 16'h0002, word);
    end
    wb_access(1'b0, reg_rdata, 16'h0000, word);
    checks++;
    if (word !== 16'h0000)
    begin
      errors++;
      $display("Fail reset rdata: expected %h, actual %h", 16'h0000, word);
    end

    // Known contents in every peripheral register.
    for (n = 0; n < 8; n++)
      issue_cmd(1'b1, 3'(n), 8'($urandom));
    wait_idle();

    addr = 3'($urandom_range(7, 0));
    issue_cmd(1'b1, addr, 8'($urandom));
    wait_idle();
    issue_cmd(1'b0, addr, 8'($urandom));
    wait_idle();
    wb_access(1'b0, reg_rdata, 16'h0000, word);
    expected = 16'h8000 | {8'h00, ref_regs[addr]};
    checks++;
    if (word !== expected)
    begin
      errors++;
      $display("Fail write then read: expected %h, actual %h", expected, word);
    end

    for (n = 0; n < num_random; n++)
    begin
      addr = 3'($urandom_range(7, 0));
      data = 8'($urandom);
      if ($urandom_range(1, 0) == 1)
      begin
        issue_cmd(1'b1, addr, data);
        wait_idle();
      end
      else
      begin
        issue_cmd(1'b0, addr, data);
        wait_idle();
        pop_result(word);
        expected = 16'h8000 | {8'h00, ref_regs[addr]};
        checks++;
        if (word !== expected)
        begin
          errors++;
          $display("Fail random read %0d: expected %h, actual %h", n, expected, word);
        end
      end
    end

    for (n = 0; n < 5; n++)
      issue_cmd(1'b1, 3'(n), 8'($urandom));
    wb_access(1'b0, reg_status, 16'h0000, word);
    checks++;
    if (word[0] !== 1'b1)
    begin
      errors++;
      $display("Fail command FIFO full: expected %b, actual %b", 1'b1, word[0]);
    end
    wait_idle();
    for (n = 0; n < 5; n++)
    begin
      issue_cmd(1'b0, 3'(n), 8'h00);
      wait_idle();
      pop_result(word);
      expected = 16'h8000 | {8'h00, ref_regs[n]};
      checks++;
      if (word !== expected)
      begin
        errors++;
        $display("Fail burst readback %0d: expected %h, actual %h", n, expected, word);
      end
    end

    for (n = 0; n < 6; n++)
    begin
      queued_addr[n] = 3'($urandom_range(7, 0));
      issue_cmd(1'b0, queued_addr[n], 8'($urandom));
    end
    wait_master_stall();
    wb_access(1'b0, reg_status, 16'h0000, word);
    checks++;
    if (word !== 16'h0004)
    begin
      errors++;
      $display("Fail stalled status: expected %h, actual %h", 16'h0004, word);
    end
    for (n = 0; n < 6; n++)
    begin
      pop_result(word);
      expected = 16'h8000 | {8'h00, ref_regs[queued_addr[n]]};
      checks++;
      if (word !== expected)
      begin
        errors++;
        $display("Fail queued read %0d: expected %h, actual %h", n, expected, word);
      end
    end
    wait_idle();
    finish_run();
  end

endmodule

`default_nettype wire

//--- wb_spi_regs.sv
`default_nettype none

`include "spi_macros.svh"

module wb_spi_regs
  import spi_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [1:0]               wb_adr,
  input  logic [`SPI_WB_WIDTH-1:0] wb_dat_w,
  output logic [`SPI_WB_WIDTH-1:0] wb_dat_r,
  output logic                     wb_ack,
  output logic                     cmd_valid,
  input  logic                     cmd_ready,
  output spi_cmd_t                 cmd_data,
  input  logic                     rd_valid,
  output logic                     rd_ready,
  input  spi_rdata_t               rd_data,
  input  logic                     busy
);

  localparam int pad_w = `SPI_WB_WIDTH - `SPI_READ_WIDTH - 1;

  logic                     access;
  wb_reg_t                  reg_sel;
  logic [`SPI_WB_WIDTH-1:0] rdata_word;
  logic [`SPI_WB_WIDTH-1:0] status_word;

  // A new access is any strobe cycle not already being acked.
  assign access  = wb_cyc && wb_stb && !wb_ack;
  assign reg_sel = wb_reg_t'(wb_adr);

  assign cmd_valid = access && wb_we && (reg_sel == reg_cmd);
  assign cmd_data  = wb_dat_w[`SPI_CMD_WIDTH-1:0];
  assign rd_ready  = access && !wb_we && (reg_sel == reg_rdata);

  assign rdata_word  = rd_valid ? {1'b1, {pad_w{1'b0}}, rd_data} : '0;
  assign status_word = {{(`SPI_WB_WIDTH-3){1'b0}}, busy, !rd_valid, !cmd_ready};

  // Command writes wait here while the FIFO is full.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      wb_ack <= 1'b0;
    else
      wb_ack <= access && !(cmd_valid && !cmd_ready);
  end

  always_ff @(posedge clk)
  begin
    if (access && !wb_we)
    begin
      case (reg_sel)
        reg_rdata:  wb_dat_r <= rdata_word;
        reg_status: wb_dat_r <= status_word;
        default:    wb_dat_r <= '0;
      endcase
    end
  end

  a_ack_in_strobe: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_stb);

endmodule

`default_nettype wire
